/* flist.f */
+incdir+logic
logic/stlb_pkg.sv
logic/stlb_paddr_ram.sv
logic/stlb_update_decode.sv
logic/stlb_entry_table.sv
logic/stlb_lookup.sv
logic/stlb_top.sv
test/stlb_clock_gen.sv
test/stlb_properties.sv
test/stlb_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0 -Wno-fatal
TOP       ?= stlb_tb
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "RESULT: FAIL" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "RESULT: PASS" $(LOG) || { echo "simulation ended without a result"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* test/stlb_tb.sv */
// stlb testbench
`timescale 1ns/10ps
`default_nettype none
`include "stlb_params.svh"

module stlb_tb;

localparam int vb      = `STLB_VPN_BITS;
localparam int pb      = `STLB_PPN_BITS;
localparam int db      = `STLB_PID_BITS;
localparam int ob      = `STLB_ORDER;
localparam int nw      = `STLB_WAYS;
localparam int run_max = 1 << `STLB_ORDER;
localparam int cnt_max = (1 << `STLB_REF_BITS) - 1;

localparam logic [1:0] k_map    = 2'd0;
localparam logic [1:0] k_unmap  = 2'd1;
localparam logic [1:0] k_lookup = 2'd2;

typedef struct packed {
  logic [2:0]    test;
  logic [1:0]    kind;
  logic          hold;  // upd_valid stays high into the next word
  logic [vb-1:0] vpn;
  logic [db-1:0] pid;
  logic          hit;   // expected lookup result
} row_t;

typedef struct packed {
  logic [2:0]    test;
  logic [vb-1:0] vpn;
  logic          hit;
  logic [pb-1:0] ppn;
  logic [31:0]   due;   // cycle the response must show up in
} rsp_t;

logic                      aclk, aresetn;
logic                      upd_valid, upd_ready;
logic [`STLB_UPD_BITS-1:0] upd_data;
logic                      lkp_valid;
logic [vb-1:0]             lkp_vpn;
logic [db-1:0]             lkp_pid;
logic                      rsp_valid, rsp_hit;
logic [pb-1:0]             rsp_ppn;

row_t        rows[$];
rsp_t        exp_q[$];
int          n_rows;
int          cur_test;
int          err_cnt [1:6];
int          n_xfer, n_upd, n_checked;
int          n_cycle;
logic [31:0] rng;

// reference model of the ways
logic [vb-1:0] m_base [nw];
logic [db-1:0] m_pid  [nw];
int            m_size [nw];
int            m_cnt  [nw];
logic [pb-1:0] m_ppn  [nw][run_max];

stlb_clock_gen u_clk (
  .aclk    (aclk),
  .aresetn (aresetn)
);

stlb_top uut (
  .aclk      (aclk),
  .aresetn   (aresetn),
  .upd_valid (upd_valid),
  .upd_data  (upd_data),
  .upd_ready (upd_ready),
  .lkp_valid (lkp_valid),
  .lkp_vpn   (lkp_vpn),
  .lkp_pid   (lkp_pid),
  .rsp_valid (rsp_valid),
  .rsp_hit   (rsp_hit),
  .rsp_ppn   (rsp_ppn)
);

function automatic logic [31:0] xorshift32(input logic [31:0] x);
  logic [31:0] y;
  y = x ^ (x << 13);
  y = y ^ (y >> 17);
  y = y ^ (y << 5);
  return y;
endfunction

function automatic logic [`STLB_UPD_BITS-1:0] make_word(input logic map,
    input logic [vb-1:0] vpn, input logic [db-1:0] pid, input logic [pb-1:0] ppn);
  logic [`STLB_UPD_BITS-1:0] w;
  w = '0;
  w[`STLB_UPD_PPN_LSB +: pb] = ppn;
  w[`STLB_UPD_VPN_LSB +: vb] = vpn;
  w[`STLB_UPD_PID_LSB +: db] = pid;
  w[`STLB_UPD_MAP_BIT]       = map;
  return w;
endfunction

function automatic string test_name(input int t);
  case (t)
    1:       return "new entry and lookup";
    2:       return "append and run limit";
    3:       return "modify";
    4:       return "delete";
    5:       return "replacement";
    default: return "back-pressure and pipelining";
  endcase
endfunction

// ----------------------------------------------------------
// reference model
// ----------------------------------------------------------
// run holding vpn, highest way wins, -1 when none
function automatic int run_way(input logic [vb-1:0] vpn, input logic [db-1:0] pid,
                               input logic any_pid);
  int w;
  w = -1;
  for (int i = 0; i < nw; i++) begin
    if (m_size[i] > 0 && vpn >= m_base[i] && int'(vpn - m_base[i]) < m_size[i] &&
        (any_pid || pid == m_pid[i])) w = i;
  end
  return w;
endfunction

function automatic int victim_way();
  int v;
  v = -1;
  for (int i = nw - 1; i >= 0; i--) begin
    if (m_size[i] == 0) v = i;  // lowest empty
  end
  if (v < 0) begin
    v = 0;
    for (int i = 0; i < nw; i++) begin
      if (m_cnt[i] <= m_cnt[v]) v = i;  // ties to the higher way
    end
  end
  return v;
endfunction

task automatic model_update(input logic [1:0] kind, input logic [vb-1:0] vpn,
                            input logic [db-1:0] pid, input logic [pb-1:0] ppn);
  int w;
  w = run_way(vpn, pid, kind == k_unmap);
  if (kind == k_unmap) begin
    if (w >= 0) m_size[w] = 0;
  end else if (w >= 0) begin
    m_ppn[w][ob'(vpn - m_base[w])] = ppn;
  end else begin
    for (int i = 0; i < nw; i++) begin
      if (m_size[i] > 0 && m_size[i] < run_max && m_pid[i] == pid &&
          vpn >= m_base[i] && int'(vpn - m_base[i]) == m_size[i]) w = i;
    end
    if (w >= 0) begin
      m_ppn[w][ob'(m_size[w])] = ppn;
      m_size[w]++;
    end else begin
      w = victim_way();
      m_base[w]   = vpn;
      m_pid[w]    = pid;
      m_size[w]   = 1;
      m_cnt[w]    = 1;
      m_ppn[w][0] = ppn;
    end
  end
endtask

task automatic model_lookup(input logic [vb-1:0] vpn, input logic [db-1:0] pid,
                            output logic hit, output logic [pb-1:0] ppn);
  int w;
  w   = run_way(vpn, pid, 1'b0);
  hit = (w >= 0);
  ppn = '0;
  if (w >= 0) begin
    ppn = m_ppn[w][ob'(vpn - m_base[w])];
    if (m_cnt[w] < cnt_max) m_cnt[w]++;
  end
endtask

// ----------------------------------------------------------
// stimulus table
// ----------------------------------------------------------
task automatic add_row(input int test, input logic [1:0] kind, input logic hold,
                       input int vpn, input int pid, input logic hit);
  row_t r;
  r.test = 3'(test);
  r.kind = kind;
  r.hold = hold;
  r.vpn  = vb'(vpn);
  r.pid  = db'(pid);
  r.hit  = hit;
  rows.push_back(r);
endtask

task automatic build_table();
  add_row(1, k_map, 0, 'h100, 3, 0);
  add_row(1, k_lookup, 0, 'h100, 3, 1);
  add_row(1, k_lookup, 0, 'h100, 4, 0);
  for (int v = 'h101; v <= 'h10f; v++) add_row(2, k_map, 0, v, 3, 0);
  for (int v = 'h100; v <= 'h10f; v++) add_row(2, k_lookup, 0, v, 3, 1);
  add_row(2, k_map, 0, 'h110, 3, 0);    // run full, new way
  add_row(2, k_lookup, 0, 'h110, 3, 1);
  add_row(2, k_lookup, 0, 'h10f, 3, 1);
  add_row(2, k_lookup, 0, 'h111, 3, 0);
  add_row(3, k_map, 0, 'h105, 3, 0);
  add_row(3, k_lookup, 0, 'h104, 3, 1);
  add_row(3, k_lookup, 0, 'h105, 3, 1);
  add_row(3, k_lookup, 0, 'h106, 3, 1);
  add_row(4, k_map, 0, 'h200, 5, 0);
  add_row(4, k_map, 0, 'h201, 5, 0);
  add_row(4, k_unmap, 0, 'h10a, 7, 0);  // other pid still deletes
  add_row(4, k_lookup, 0, 'h100, 3, 0);
  add_row(4, k_lookup, 0, 'h10a, 3, 0);
  add_row(4, k_lookup, 0, 'h10f, 3, 0);
  add_row(4, k_lookup, 0, 'h110, 3, 1);
  add_row(4, k_lookup, 0, 'h201, 5, 1);
  // counts 1 3 2 1, tie goes to way 3
  add_row(5, k_map, 0, 'h300, 1, 0);
  add_row(5, k_map, 0, 'h400, 2, 0);
  add_row(5, k_map, 0, 'h500, 2, 0);
  add_row(5, k_lookup, 0, 'h400, 2, 0);
  add_row(5, k_lookup, 0, 'h500, 2, 1);
  add_row(5, k_lookup, 0, 'h500, 2, 1);
  add_row(5, k_lookup, 0, 'h300, 1, 1);
  add_row(5, k_lookup, 0, 'h300, 1, 1);
  add_row(5, k_map, 0, 'h600, 1, 0);    // way 2 has the lowest count
  add_row(5, k_lookup, 0, 'h200, 5, 0);
  add_row(5, k_lookup, 0, 'h201, 5, 0);
  add_row(5, k_lookup, 0, 'h600, 1, 1);
  add_row(5, k_lookup, 0, 'h300, 1, 1);
  add_row(5, k_lookup, 0, 'h110, 3, 1);
  add_row(5, k_lookup, 0, 'h500, 2, 1);
  add_row(6, k_map, 1, 'h700, 9, 0);
  add_row(6, k_map, 1, 'h701, 9, 0);
  add_row(6, k_unmap, 1, 'h300, 0, 0);
  add_row(6, k_map, 0, 'h702, 9, 0);
  add_row(6, k_lookup, 0, 'h700, 9, 1);
  add_row(6, k_lookup, 0, 'h701, 9, 1);
  add_row(6, k_lookup, 0, 'h702, 9, 1);
  add_row(6, k_lookup, 0, 'h703, 9, 0);
  add_row(6, k_lookup, 0, 'h300, 1, 0);
  add_row(6, k_lookup, 0, 'h600, 1, 0);
  add_row(6, k_lookup, 0, 'h110, 3, 1);
  add_row(6, k_lookup, 0, 'h500, 2, 1);
  add_row(6, k_lookup, 0, 'h701, 9, 1);
endtask

// ----------------------------------------------------------
// drivers
// ----------------------------------------------------------
task automatic send_update(input logic [`STLB_UPD_BITS-1:0] word, input logic hold);
  // a held word follows right after the previous transfer
  if (!upd_valid) begin
    @(posedge aclk);
    #1;
  end
  upd_valid = 1'b1;
  upd_data  = word;
  @(negedge aclk);
  while (!upd_ready) @(negedge aclk);
  @(posedge aclk);  // word taken here
  #1;
  if (!hold) begin
    upd_valid = 1'b0;
    @(negedge aclk);
    while (!upd_ready) @(negedge aclk);
  end
endtask

task automatic issue_lookup(input logic [vb-1:0] vpn, input logic [db-1:0] pid);
  @(posedge aclk);
  #1;
  lkp_valid = 1'b1;
  lkp_vpn   = vpn;
  lkp_pid   = pid;
endtask

task automatic end_lookups();
  @(posedge aclk);
  #1;
  lkp_valid = 1'b0;
endtask

task automatic drain_responses();
  while (exp_q.size() != 0) @(negedge aclk);
endtask

task automatic finish_test(input int t);
  drain_responses();
  if (n_xfer != n_upd) begin
    $display("update transfer count wrong: %0d words sent, %0d transfers seen",
             n_upd, n_xfer);
    err_cnt[t]++;
    n_upd = n_xfer;
  end
  if (err_cnt[t] == 0) $display("test %0d %s: ok", t, test_name(t));
  else $display("test %0d %s: %0d errors", t, test_name(t), err_cnt[t]);
endtask

always @(posedge aclk) n_cycle++;

// transfer happens on the next rising edge
always @(negedge aclk) begin
  if (aresetn && upd_valid && upd_ready) n_xfer++;
end

// response checker, in order
always @(negedge aclk) begin
  rsp_t e;
  if (aresetn && rsp_valid) begin
    if (exp_q.size() == 0) begin
      $display("response arrived with no lookup outstanding");
      err_cnt[cur_test]++;
    end else begin
      e = exp_q.pop_front();
      n_checked++;
      if (n_cycle != int'(e.due)) begin
        $display("response for vpn 0x%h came in cycle %0d instead of cycle %0d",
                 e.vpn, n_cycle, e.due);
        err_cnt[e.test]++;
      end
      if (rsp_hit !== e.hit) begin
        $display("FAILED rsp_hit vpn 0x%h: expected 0x%h, got 0x%h", e.vpn, e.hit, rsp_hit);
        err_cnt[e.test]++;
      end
      if (rsp_ppn !== e.ppn) begin
        $display("FAILED rsp_ppn vpn 0x%h: expected 0x%h, got 0x%h", e.vpn, e.ppn, rsp_ppn);
        err_cnt[e.test]++;
      end
    end
  end
end

initial begin
  wait (n_rows != 0);
  repeat (n_rows * 20 + 200) @(posedge aclk);
  $display("timeout: run did not finish within %0d cycles", n_rows * 20 + 200);
  $display("RESULT: FAIL");
  $finish;
end

initial begin
  row_t          r;
  rsp_t          e;
  logic          m_hit;
  logic [pb-1:0] m_ppn_val;
  logic [pb-1:0] ppn;
  int            total;
  upd_valid = 1'b0;
  upd_data  = '0;
  lkp_valid = 1'b0;
  lkp_vpn   = '0;
  lkp_pid   = '0;
  rng       = 32'h767041de;
  for (int i = 0; i < nw; i++) begin
    m_size[i] = 0;
    m_cnt[i]  = 0;
  end
  build_table();
  n_rows   = rows.size();
  cur_test = int'(rows[0].test);
  wait (aresetn === 1'b1);
  if (upd_ready !== 1'b1) begin
    $display("FAILED upd_ready after reset: expected 0x1, got 0x%h", upd_ready);
    err_cnt[1]++;
  end
  for (int i = 0; i < n_rows; i++) begin
    r = rows[i];
    if (int'(r.test) != cur_test) begin
      finish_test(cur_test);
      cur_test = int'(r.test);
    end
    if (r.kind == k_lookup) begin
      model_lookup(r.vpn, r.pid, m_hit, m_ppn_val);
      if (m_hit != r.hit) begin
        $display("table row %0d expects hit %0d but the model says %0d", i, r.hit, m_hit);
        err_cnt[cur_test]++;
      end
      e.test = r.test;
      e.vpn  = r.vpn;
      e.hit  = r.hit;
      e.ppn  = r.hit ? m_ppn_val : '0;  // zero on a miss
      issue_lookup(r.vpn, r.pid);
      e.due  = 32'(n_cycle + 4);        // sampled next edge, answered 4 cycles on
      exp_q.push_back(e);
      if (i + 1 >= n_rows || rows[i + 1].kind != k_lookup || rows[i + 1].test != r.test) begin
        end_lookups();
      end
    end else begin
      drain_responses();  // keep lookups clear of updates
      rng = xorshift32(rng);
      ppn = rng[pb-1:0];
      model_update(r.kind, r.vpn, r.pid, ppn);
      send_update(make_word(r.kind == k_map, r.vpn, r.pid, ppn), r.hold);
      n_upd++;
    end
  end
  finish_test(cur_test);
  total = 0;
  for (int t = 1; t <= 6; t++) total += err_cnt[t];
  $display("tests 6, lookups checked %0d, updates %0d, errors %0d", n_checked, n_upd, total);
  if (total == 0) begin
    $display("RESULT: PASS");
  end else begin
    $display("RESULT: FAIL");
  end
  $finish;
end

endmodule

`default_nettype wire

/* test/stlb_properties.sv */
// stlb interface checks
`timescale 1ns/10ps
`default_nettype none

module stlb_properties (
  input logic                 aclk,
  input logic                 aresetn,
  input logic                 upd_valid,
  input logic                 upd_ready,
  input stlb_pkg::upd_state_t upd_state,
  input logic                 lkp_valid,
  input logic                 rsp_valid,
  input logic                 rsp_hit
);

import stlb_pkg::*;

// a taken word starts the settle sequence
a_xfer_busy: assert property (@(posedge aclk) disable iff (!aresetn)
  (upd_valid && upd_ready) |=> (!upd_ready && upd_state == upd_wait0))
  else $error("upd_ready high or FSM not in wait0 after a transfer");

// low through wait1 and check as well
a_busy_settle: assert property (@(posedge aclk) disable iff (!aresetn)
  ($past(upd_valid && upd_ready, 2) || $past(upd_valid && upd_ready, 3)) |-> !upd_ready)
  else $error("upd_ready high during the settle cycles of an update");

// at most one action state, then idle again
a_busy_bound: assert property (@(posedge aclk) disable iff (!aresetn)
  $past(upd_valid && upd_ready, 5) |-> (upd_ready || $past(upd_ready)))
  else $error("update FSM not back in idle 5 cycles after a transfer");

// ----------------------------------------------------------
// lookup response timing
// ----------------------------------------------------------
a_rsp_latency: assert property (@(posedge aclk) disable iff (!aresetn)
  rsp_valid == $past(lkp_valid, 4))
  else $error("rsp_valid does not follow lkp_valid by 4 cycles");

a_hit_valid: assert property (@(posedge aclk) disable iff (!aresetn)
  rsp_hit |-> rsp_valid)
  else $error("rsp_hit high without rsp_valid");

endmodule

bind stlb_top stlb_properties u_props (
  .aclk      (aclk),
  .aresetn   (aresetn),
  .upd_valid (upd_valid),
  .upd_ready (upd_ready),
  .upd_state (u_decode.state),
  .lkp_valid (lkp_valid),
  .rsp_valid (rsp_valid),
  .rsp_hit   (rsp_hit)
);

`default_nettype wire

/* test/stlb_clock_gen.sv */
// stlb testbench clock and reset
`timescale 1ns/10ps
`default_nettype none

module stlb_clock_gen (
  output logic aclk,
  output logic aresetn
);

// 8 ns period
initial begin
  aclk = 1'b0;
  forever #4 aclk = ~aclk;
end

initial begin
  aresetn = 1'b0;
  repeat (10) @(posedge aclk);
  #1 aresetn = 1'b1;  // released just after the edge
end

endmodule

`default_nettype wire

/* logic/stlb_top.sv */
// stlb top level
`timescale 1ns/10ps
`default_nettype none
`include "stlb_params.svh"

module stlb_top (
  input  logic                      aclk,
  input  logic                      aresetn,
  input  logic                      upd_valid,
  input  logic [`STLB_UPD_BITS-1:0] upd_data,
  output logic                      upd_ready,
  input  logic                      lkp_valid,
  input  logic [`STLB_VPN_BITS-1:0] lkp_vpn,
  input  logic [`STLB_PID_BITS-1:0] lkp_pid,
  output logic                      rsp_valid,
  output logic                      rsp_hit,
  output logic [`STLB_PPN_BITS-1:0] rsp_ppn
);

import stlb_pkg::*;

// update path
logic [`STLB_VPN_BITS-1:0]                 cur_vpn;
logic [`STLB_PPN_BITS-1:0]                 cur_ppn;
logic [`STLB_PID_BITS-1:0]                 cur_pid;
upd_action_t                               action;
logic                                      action_strobe;
logic [`STLB_WAY_BITS-1:0]                 hit_way;

// entry state
logic [`STLB_WAYS-1:0][`STLB_VPN_BITS-1:0] entry_vpn;
logic [`STLB_WAYS-1:0][`STLB_PID_BITS-1:0] entry_pid;
logic [`STLB_WAYS-1:0][`STLB_ORDER:0]      entry_size;

// PPN tables
logic [`STLB_WAYS-1:0]                     ram_we;
logic [`STLB_ORDER-1:0]                    ram_wr_offset;
logic [`STLB_PPN_BITS-1:0]                 ram_wr_ppn;
logic [`STLB_WAYS-1:0][`STLB_ORDER-1:0]    ram_rd_offset;
logic [`STLB_WAYS-1:0][`STLB_PPN_BITS-1:0] ram_rd_ppn;

logic                                      lkp_hit_strobe;
logic [`STLB_WAY_BITS-1:0]                 lkp_hit_way;

stlb_update_decode u_decode (
  .aclk          (aclk),
  .aresetn       (aresetn),
  .upd_valid     (upd_valid),
  .upd_data      (upd_data),
  .upd_ready     (upd_ready),
  .entry_vpn     (entry_vpn),
  .entry_pid     (entry_pid),
  .entry_size    (entry_size),
  .cur_vpn       (cur_vpn),
  .cur_ppn       (cur_ppn),
  .cur_pid       (cur_pid),
  .action        (action),
  .action_strobe (action_strobe),
  .hit_way       (hit_way)
);

stlb_entry_table u_table (
  .aclk           (aclk),
  .aresetn        (aresetn),
  .cur_vpn        (cur_vpn),
  .cur_ppn        (cur_ppn),
  .cur_pid        (cur_pid),
  .action         (action),
  .action_strobe  (action_strobe),
  .hit_way        (hit_way),
  .lkp_hit_strobe (lkp_hit_strobe),
  .lkp_hit_way    (lkp_hit_way),
  .entry_vpn      (entry_vpn),
  .entry_pid      (entry_pid),
  .entry_size     (entry_size),
  .ram_we         (ram_we),
  .ram_wr_offset  (ram_wr_offset),
  .ram_wr_ppn     (ram_wr_ppn)
);

// ----------------------------------------------------------
// one PPN table per way
// ----------------------------------------------------------
for (genvar i = 0; i < `STLB_WAYS; i++) begin : g_way
  stlb_paddr_ram u_ram (
    .aclk      (aclk),
    .we        (ram_we[i]),
    .wr_offset (ram_wr_offset),
    .wr_ppn    (ram_wr_ppn),
    .rd_offset (ram_rd_offset[i]),
    .rd_ppn    (ram_rd_ppn[i])
  );
end

stlb_lookup u_lookup (
  .aclk           (aclk),
  .aresetn        (aresetn),
  .lkp_valid      (lkp_valid),
  .lkp_vpn        (lkp_vpn),
  .lkp_pid        (lkp_pid),
  .entry_vpn      (entry_vpn),
  .entry_pid      (entry_pid),
  .entry_size     (entry_size),
  .ram_rd_ppn     (ram_rd_ppn),
  .ram_rd_offset  (ram_rd_offset),
  .lkp_hit_strobe (lkp_hit_strobe),
  .lkp_hit_way    (lkp_hit_way),
  .rsp_valid      (rsp_valid),
  .rsp_hit        (rsp_hit),
  .rsp_ppn        (rsp_ppn)
);

endmodule

`default_nettype wire

/* logic/stlb_lookup.sv */
// stlb lookup pipeline
`timescale 1ns/10ps
`default_nettype none
`include "stlb_params.svh"

module stlb_lookup (
  input  logic                                      aclk,
  input  logic                                      aresetn,
  input  logic                                      lkp_valid,
  input  logic [`STLB_VPN_BITS-1:0]                 lkp_vpn,
  input  logic [`STLB_PID_BITS-1:0]                 lkp_pid,
  input  logic [`STLB_WAYS-1:0][`STLB_VPN_BITS-1:0] entry_vpn,
  input  logic [`STLB_WAYS-1:0][`STLB_PID_BITS-1:0] entry_pid,
  input  logic [`STLB_WAYS-1:0][`STLB_ORDER:0]      entry_size,
  input  logic [`STLB_WAYS-1:0][`STLB_PPN_BITS-1:0] ram_rd_ppn,
  output logic [`STLB_WAYS-1:0][`STLB_ORDER-1:0]    ram_rd_offset,
  output logic                                      lkp_hit_strobe,
  output logic [`STLB_WAY_BITS-1:0]                 lkp_hit_way,
  output logic                                      rsp_valid,
  output logic                                      rsp_hit,
  output logic [`STLB_PPN_BITS-1:0]                 rsp_ppn
);

localparam int nw = `STLB_WAYS;
localparam int wb = `STLB_WAY_BITS;
localparam int vb = `STLB_VPN_BITS;
localparam int ob = `STLB_ORDER;

logic [nw-1:0][vb-1:0] diff;
logic [nw-1:0]         hit_vec, s1_hit_vec;
logic [nw-1:0][ob-1:0] s1_offset;
logic                  s1_valid, s2_valid, s2_hit, s3_valid, s3_hit;
logic [wb-1:0]         enc_way, s2_way, s3_way;

// stage 1 compare
always_comb begin
  for (int i = 0; i < nw; i++) begin
    diff[i]    = lkp_vpn - entry_vpn[i];
    hit_vec[i] = (lkp_vpn >= entry_vpn[i]) && (diff[i] < vb'(entry_size[i])) &&
                 (lkp_pid == entry_pid[i]);
  end
end

// stage 2 encode, highest way wins
always_comb begin
  enc_way = '0;
  for (int i = 0; i < nw; i++) begin
    if (s1_hit_vec[i]) enc_way = wb'(i);
  end
end

// ----------------------------------------------------------
// pipeline valid and hit flags
// ----------------------------------------------------------
always_ff @(posedge aclk) begin
  if (aresetn == 1'b0) begin
    s1_valid  <= 1'b0;
    s2_valid  <= 1'b0;
    s2_hit    <= 1'b0;
    s3_valid  <= 1'b0;
    s3_hit    <= 1'b0;
    rsp_valid <= 1'b0;
    rsp_hit   <= 1'b0;
  end else begin
    s1_valid  <= lkp_valid;
    s2_valid  <= s1_valid;
    s2_hit    <= s1_valid && (|s1_hit_vec);
    s3_valid  <= s2_valid;
    s3_hit    <= s2_hit;
    rsp_valid <= s3_valid;
    rsp_hit   <= s3_hit;
  end
end

always_ff @(posedge aclk) begin
  s1_hit_vec <= hit_vec;
  for (int i = 0; i < nw; i++) begin
    s1_offset[i]     <= diff[i][ob-1:0];
    ram_rd_offset[i] <= s1_offset[enc_way];  // same page index to every way
  end
  s2_way  <= enc_way;
  s3_way  <= s2_way;                           // aligned with the RAM read
  rsp_ppn <= s3_hit ? ram_rd_ppn[s3_way] : '0;
end

// reference count bump
assign lkp_hit_strobe = s2_hit;
assign lkp_hit_way    = s2_way;

endmodule

`default_nettype wire

/* logic/stlb_entry_table.sv */
// stlb entry table and replacement
`timescale 1ns/10ps
`default_nettype none
`include "stlb_params.svh"

module stlb_entry_table (
  input  logic                                      aclk,
  input  logic                                      aresetn,
  input  logic [`STLB_VPN_BITS-1:0]                 cur_vpn,
  input  logic [`STLB_PPN_BITS-1:0]                 cur_ppn,
  input  logic [`STLB_PID_BITS-1:0]                 cur_pid,
  input  stlb_pkg::upd_action_t                     action,
  input  logic                                      action_strobe,
  input  logic [`STLB_WAY_BITS-1:0]                 hit_way,
  input  logic                                      lkp_hit_strobe,
  input  logic [`STLB_WAY_BITS-1:0]                 lkp_hit_way,
  output logic [`STLB_WAYS-1:0][`STLB_VPN_BITS-1:0] entry_vpn,
  output logic [`STLB_WAYS-1:0][`STLB_PID_BITS-1:0] entry_pid,
  output logic [`STLB_WAYS-1:0][`STLB_ORDER:0]      entry_size,
  output logic [`STLB_WAYS-1:0]                     ram_we,
  output logic [`STLB_ORDER-1:0]                    ram_wr_offset,
  output logic [`STLB_PPN_BITS-1:0]                 ram_wr_ppn
);

import stlb_pkg::*;

localparam int wb   = `STLB_WAY_BITS;
localparam int half = `STLB_WAYS / 2;
localparam logic [`STLB_ORDER:0]      size_one = 1;
localparam logic [`STLB_REF_BITS-1:0] cnt_one  = 1;

logic [`STLB_WAYS-1:0][`STLB_REF_BITS-1:0] ref_cnt;

logic [1:0]                     half_free, half_free_q;
logic [1:0][wb-1:0]             half_free_way, half_free_way_q;
logic [1:0][`STLB_REF_BITS-1:0] half_min_cnt, half_min_cnt_q;
logic [1:0][wb-1:0]             half_min_way, half_min_way_q;
logic [wb-1:0]                  victim_way;
logic [`STLB_VPN_BITS-1:0]      wr_diff;

// ----------------------------------------------------------
// victim choice, one half of the ways per lane
// ----------------------------------------------------------
always_comb begin
  for (int h = 0; h < 2; h++) begin
    half_free[h]     = 1'b0;
    half_free_way[h] = '0;
    half_min_cnt[h]  = '1;
    half_min_way[h]  = '0;
    // walk down so the lowest empty way is kept
    for (int j = half - 1; j >= 0; j--) begin
      if (entry_size[h*half + j] == '0) begin
        half_free[h]     = 1'b1;
        half_free_way[h] = wb'(h*half + j);
      end
    end
    for (int j = 0; j < half; j++) begin
      if (ref_cnt[h*half + j] <= half_min_cnt[h]) begin  // ties to the upper way
        half_min_cnt[h] = ref_cnt[h*half + j];
        half_min_way[h] = wb'(h*half + j);
      end
    end
  end
end

always_ff @(posedge aclk) begin
  half_free_q     <= half_free;
  half_free_way_q <= half_free_way;
  half_min_cnt_q  <= half_min_cnt;
  half_min_way_q  <= half_min_way;
  if (half_free_q[0]) begin
    victim_way <= half_free_way_q[0];
  end else if (half_free_q[1]) begin
    victim_way <= half_free_way_q[1];
  end else if (half_min_cnt_q[1] <= half_min_cnt_q[0]) begin
    victim_way <= half_min_way_q[1];
  end else begin
    victim_way <= half_min_way_q[0];
  end
end

// ----------------------------------------------------------
// entry registers
// ----------------------------------------------------------
always_ff @(posedge aclk) begin
  if (aresetn == 1'b0) begin
    entry_size <= '0;
    ref_cnt    <= '0;
  end else begin
    if (lkp_hit_strobe && ref_cnt[lkp_hit_way] != '1) begin
      ref_cnt[lkp_hit_way] <= ref_cnt[lkp_hit_way] + cnt_one;
    end
    if (action_strobe) begin
      case (action)
        act_new_entry: begin
          entry_size[victim_way] <= size_one;
          ref_cnt[victim_way]    <= cnt_one;  // overrides a same-cycle hit
        end
        act_append: entry_size[hit_way] <= entry_size[hit_way] + size_one;
        act_delete: entry_size[hit_way] <= '0;
        default:    ;
      endcase
    end
  end
end

always_ff @(posedge aclk) begin
  if (action_strobe && action == act_new_entry) begin
    entry_vpn[victim_way] <= cur_vpn;
    entry_pid[victim_way] <= cur_pid;
  end
end

// PPN table write
always_comb begin
  ram_we        = '0;
  wr_diff       = cur_vpn - entry_vpn[hit_way];
  ram_wr_offset = wr_diff[`STLB_ORDER-1:0];
  if (action_strobe) begin
    case (action)
      act_new_entry: begin
        ram_we[victim_way] = 1'b1;
        ram_wr_offset      = '0;    // first page of the run
      end
      act_modify, act_append: ram_we[hit_way] = 1'b1;
      default: ;
    endcase
  end
end

assign ram_wr_ppn = cur_ppn;

endmodule

`default_nettype wire

/* logic/stlb_update_decode.sv */
// stlb update decoder
`timescale 1ns/10ps
`default_nettype none
`include "stlb_params.svh"

module stlb_update_decode (
  input  logic                                      aclk,
  input  logic                                      aresetn,
  input  logic                                      upd_valid,
  input  logic [`STLB_UPD_BITS-1:0]                 upd_data,
  output logic                                      upd_ready,
  input  logic [`STLB_WAYS-1:0][`STLB_VPN_BITS-1:0] entry_vpn,
  input  logic [`STLB_WAYS-1:0][`STLB_PID_BITS-1:0] entry_pid,
  input  logic [`STLB_WAYS-1:0][`STLB_ORDER:0]      entry_size,
  output logic [`STLB_VPN_BITS-1:0]                 cur_vpn,
  output logic [`STLB_PPN_BITS-1:0]                 cur_ppn,
  output logic [`STLB_PID_BITS-1:0]                 cur_pid,
  output stlb_pkg::upd_action_t                     action,
  output logic                                      action_strobe,
  output logic [`STLB_WAY_BITS-1:0]                 hit_way
);

import stlb_pkg::*;

localparam int nw = `STLB_WAYS;
localparam int wb = `STLB_WAY_BITS;
localparam int vb = `STLB_VPN_BITS;
localparam logic [`STLB_ORDER:0] run_max = 1 << `STLB_ORDER;

upd_state_t  state, state_nxt;
upd_action_t act_sel;
logic        cur_map;

logic [nw-1:0][vb-1:0] diff;
logic [nw-1:0]         mod_vec, app_vec, del_vec;       // wait0
logic [nw-1:0]         mod_vec_q, app_vec_q, del_vec_q; // wait1
logic                  mod_any, app_any, del_any;       // check
logic [wb-1:0]         mod_way, app_way, del_way, sel_way;

// highest set bit wins
function automatic logic [wb-1:0] top_way(input logic [nw-1:0] vec);
  logic [wb-1:0] way;
  way = '0;
  for (int i = 0; i < nw; i++) begin
    if (vec[i]) way = wb'(i);
  end
  return way;
endfunction

assign upd_ready = (state == upd_idle);
assign action_strobe = state inside {upd_new_entry, upd_modify, upd_append, upd_delete};

// word capture, held until the next transfer
always_ff @(posedge aclk) begin
  if (state == upd_idle && upd_valid) begin
    cur_ppn <= upd_data[`STLB_UPD_PPN_LSB +: `STLB_PPN_BITS];
    cur_vpn <= upd_data[`STLB_UPD_VPN_LSB +: `STLB_VPN_BITS];
    cur_pid <= upd_data[`STLB_UPD_PID_LSB +: `STLB_PID_BITS];
    cur_map <= upd_data[`STLB_UPD_MAP_BIT];
  end
end

// ----------------------------------------------------------
// per-way classification
// ----------------------------------------------------------
always_comb begin
  for (int i = 0; i < nw; i++) begin
    diff[i]    = cur_vpn - entry_vpn[i];
    del_vec[i] = (cur_vpn >= entry_vpn[i]) && (diff[i] < vb'(entry_size[i])); // any pid
    mod_vec[i] = del_vec[i] && (cur_pid == entry_pid[i]);
    // one page past the end, run not yet full
    app_vec[i] = (cur_vpn >= entry_vpn[i]) && (diff[i] == vb'(entry_size[i])) &&
                 (entry_size[i] != '0) && (entry_size[i] != run_max) &&
                 (cur_pid == entry_pid[i]);
  end
end

always_ff @(posedge aclk) begin
  if (aresetn == 1'b0) begin
    mod_vec_q <= '0;
    app_vec_q <= '0;
    del_vec_q <= '0;
    mod_any   <= 1'b0;
    app_any   <= 1'b0;
    del_any   <= 1'b0;
    mod_way   <= '0;
    app_way   <= '0;
    del_way   <= '0;
  end else begin
    mod_vec_q <= mod_vec;
    app_vec_q <= app_vec;
    del_vec_q <= del_vec;
    mod_any   <= |mod_vec_q;
    app_any   <= |app_vec_q;
    del_any   <= |del_vec_q;
    mod_way   <= top_way(mod_vec_q);
    app_way   <= top_way(app_vec_q);
    del_way   <= top_way(del_vec_q);
  end
end

// action priority
always_comb begin
  act_sel = act_none;
  sel_way = '0;
  if (cur_map && mod_any) begin
    act_sel = act_modify;
    sel_way = mod_way;
  end else if (cur_map && app_any) begin
    act_sel = act_append;
    sel_way = app_way;
  end else if (cur_map) begin
    act_sel = act_new_entry;  // table picks the way
  end else if (del_any) begin
    act_sel = act_delete;
    sel_way = del_way;
  end
end

// ----------------------------------------------------------
// FSM
// ----------------------------------------------------------
always_comb begin
  state_nxt = state;
  case (state)
    upd_idle:  if (upd_valid) state_nxt = upd_wait0;
    upd_wait0: state_nxt = upd_wait1;
    upd_wait1: state_nxt = upd_check;
    upd_check: begin
      case (act_sel)
        act_new_entry: state_nxt = upd_new_entry;
        act_modify:    state_nxt = upd_modify;
        act_append:    state_nxt = upd_append;
        act_delete:    state_nxt = upd_delete;
        default:       state_nxt = upd_idle;
      endcase
    end
    default:   state_nxt = upd_idle;  // single-cycle action states
  endcase
end

always_ff @(posedge aclk) begin
  if (aresetn == 1'b0) begin
    state  <= upd_idle;
    action <= act_none;
  end else begin
    state <= state_nxt;
    if (state == upd_check) action <= act_sel;
  end
end

always_ff @(posedge aclk) begin
  if (state == upd_check) hit_way <= sel_way;
end

endmodule

`default_nettype wire

/* logic/stlb_paddr_ram.sv */
// stlb per-way PPN table
`timescale 1ns/10ps
`default_nettype none
`include "stlb_params.svh"

module stlb_paddr_ram (
  input  logic                      aclk,
  input  logic                      we,
  input  logic [`STLB_ORDER-1:0]    wr_offset,
  input  logic [`STLB_PPN_BITS-1:0] wr_ppn,
  input  logic [`STLB_ORDER-1:0]    rd_offset,
  output logic [`STLB_PPN_BITS-1:0] rd_ppn
);

localparam int depth = 1 << `STLB_ORDER;

logic [`STLB_PPN_BITS-1:0] mem [depth];

// one page per entry of the run
always_ff @(posedge aclk) begin
  if (we) mem[wr_offset] <= wr_ppn;
end

always_ff @(posedge aclk) begin
  rd_ppn <= mem[rd_offset];  // registered read
end

endmodule

`default_nettype wire

/* logic/stlb_pkg.sv */
// stlb shared types
`default_nettype none

package stlb_pkg;

  // update FSM
  typedef enum logic [2:0] {
    upd_idle,
    upd_wait0,       // hit vectors settle
    upd_wait1,
    upd_check,
    upd_new_entry,
    upd_modify,
    upd_append,
    upd_delete
  } upd_state_t;

  // what the entry table does on the action strobe
  typedef enum logic [2:0] {
    act_none,
    act_new_entry,
    act_modify,
    act_append,
    act_delete
  } upd_action_t;

endpackage

`default_nettype wire

/* logic/stlb_params.svh */
// stlb widths and update word layout
`ifndef STLB_PARAMS_SVH
`define STLB_PARAMS_SVH

// geometry
`define STLB_WAYS     4
`define STLB_WAY_BITS 2
`define STLB_ORDER    4     // log2 of the longest run

// field widths
`define STLB_VPN_BITS 20
`define STLB_PPN_BITS 20
`define STLB_PID_BITS 6
`define STLB_REF_BITS 2     // saturating reference count
`define STLB_UPD_BITS 64

// update word fields, bits above the map flag are zero
`define STLB_UPD_PPN_LSB 0
`define STLB_UPD_VPN_LSB 20
`define STLB_UPD_PID_LSB 40
`define STLB_UPD_MAP_BIT 46 // 1 = map, 0 = unmap

`endif
